//--- Bender.yml
package:
  name: cpu_core

sources:
  - include_dirs:
      - include
    files:
      - design/cpu_arch_pkg.sv
      - design/cpu_ctrl_pkg.sv
      - design/cpu_decode.sv
      - design/cpu_sequencer.sv
      - design/cpu_alu.sv
      - design/cpu_registers.sv
      - design/cpu_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/cpu_tb.sv

//--- design/cpu_alu.sv
// Combinational ALU of the core: logic ops, add/subtract with carry, decimal adjust for ADC/SBC
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  cpu_ctrl_pkg::state_e  state,
    input  cpu_ctrl_pkg::ctrl_t   ctrl,
    input  cpu_arch_pkg::byte_t   regfile,
    input  cpu_arch_pkg::byte_t   din,
    input  cpu_arch_pkg::flags_t  flags,
    output cpu_arch_pkg::byte_t   result,
    output logic                  carry_out
);

    cpu_arch_pkg::byte_t ai;                  // Operand A
    cpu_arch_pkg::byte_t bi;                  // Operand B
    cpu_arch_pkg::byte_t bx;                  // B, inverted for subtract
    logic                ci;                  // Carry in
    logic [4:0]          lo;                  // Low nibble sum
    logic [4:0]          hi;                  // High nibble sum
    logic                hc;                  // Half carry into high nibble
    logic                co;                  // Adder carry out
    logic                bcd_add;
    logic                bcd_sub;
    logic [3:0]          adj_lo;
    logic [3:0]          adj_hi;

    assign ai = ctrl.load_only ? '0 : regfile;
    assign bi = (state == cpu_ctrl_pkg::FETCH) ? din : '0;
    assign bx = (ctrl.alu_op == cpu_ctrl_pkg::OP_SUB) ? ~bi : bi;

    always_comb begin
        if (state == cpu_ctrl_pkg::REG) begin
            ci = ctrl.inc;                    // INX/INY
        end else if (state == cpu_ctrl_pkg::FETCH) begin
            ci = ctrl.compare | (ctrl.adc_sbc & flags.carry);
        end else begin
            ci = 1'b0;
        end
    end

    assign bcd_add = ctrl.adc_bcd & (state == cpu_ctrl_pkg::FETCH);
    assign bcd_sub = ctrl.adc_sbc & flags.decimal & (state == cpu_ctrl_pkg::FETCH) &
                     (ctrl.alu_op == cpu_ctrl_pkg::OP_SUB);

    // Nibble adder, BCD add carries on digits above 9
    always_comb begin
        lo = {1'b0, ai[3:0]} + {1'b0, bx[3:0]} + {4'b0, ci};
        hc = bcd_add ? (lo > 5'd9) : lo[4];
        hi = {1'b0, ai[7:4]} + {1'b0, bx[7:4]} + {4'b0, hc};
        co = bcd_add ? (hi > 5'd9) : hi[4];
    end

    always_comb begin
        if (bcd_add) begin
            adj_lo = hc ? 4'd6 : 4'd0;        // Skip 10..15
            adj_hi = co ? 4'd6 : 4'd0;
        end else if (bcd_sub) begin
            adj_lo = hc ? 4'd0 : 4'd10;       // Digit borrowed
            adj_hi = co ? 4'd0 : 4'd10;
        end else begin
            adj_lo = 4'd0;
            adj_hi = 4'd0;
        end
    end

    always_comb begin
        carry_out = 1'b0;
        case (ctrl.alu_op)
            cpu_ctrl_pkg::OP_OR:  result = ai | bi;
            cpu_ctrl_pkg::OP_AND: result = ai & bi;
            cpu_ctrl_pkg::OP_EOR: result = ai ^ bi;
            cpu_ctrl_pkg::OP_ADD,
            cpu_ctrl_pkg::OP_SUB: begin
                result    = {hi[3:0] + adj_hi, lo[3:0] + adj_lo};
                carry_out = co;
            end
            default:              result = ai;        // Transfers
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpu_arch_pkg.sv
// Architectural types of the core (data, addresses, registers, flags, bus); compile before other RTL
`default_nettype none

`include "cpu_defs.svh"

package cpu_arch_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;   // One data byte
    typedef logic [`CPU_ADDR_W-1:0] addr_t;   // Bus address

    // Register file index
    typedef enum logic [1:0] {
        SEL_A = 2'd0,                         // Accumulator
        SEL_X = 2'd1,                         // Index X
        SEL_Y = 2'd2                          // Index Y
    } reg_sel_e;

    // Only the flags a program can still observe
    typedef struct packed {
        logic carry;                          // C, from ADC/SBC/CMP or CLC/SEC
        logic decimal;                        // D, BCD mode for ADC/SBC
    } flags_t;

    // One bus cycle as driven by the core
    typedef struct packed {
        addr_t addr;                          // Read or write address
        byte_t wdata;                         // Store data
        logic  we;                            // Write strobe, qualified by rdy
    } bus_req_t;

endpackage

`default_nettype wire

//--- design/cpu_core.sv
// Top level of the 8-bit core; connect to a memory that answers bus.addr combinationally
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rdy,      // Low stalls the whole core
    input  cpu_arch_pkg::byte_t     rdata,
    output cpu_arch_pkg::bus_req_t  bus
);

    cpu_ctrl_pkg::state_e state;
    cpu_ctrl_pkg::ctrl_t  ctrl;
    cpu_arch_pkg::byte_t  ir;
    cpu_arch_pkg::byte_t  din;
    cpu_arch_pkg::byte_t  regfile;
    cpu_arch_pkg::byte_t  result;
    cpu_arch_pkg::flags_t flags;
    logic                 carry_out;

    cpu_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .rdy     (rdy),
        .rdata   (rdata),
        .ctrl    (ctrl),
        .regfile (regfile),
        .state   (state),
        .ir      (ir),
        .din     (din),
        .bus     (bus)
    );

    cpu_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .state (state),
        .ir    (ir),
        .flags (flags),
        .ctrl  (ctrl)
    );

    cpu_alu u_alu (
        .state     (state),
        .ctrl      (ctrl),
        .regfile   (regfile),
        .din       (din),
        .flags     (flags),
        .result    (result),
        .carry_out (carry_out)
    );

    cpu_registers u_registers (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .state     (state),
        .ctrl      (ctrl),
        .result    (result),
        .carry_out (carry_out),
        .regfile   (regfile),
        .flags     (flags)
    );

endmodule

`default_nettype wire

//--- design/cpu_ctrl_pkg.sv
// Microarchitecture types of the core (sequencer states, ALU ops, decoded control word)
`default_nettype none

package cpu_ctrl_pkg;

    // Reduced sequencer, one path per addressing mode
    typedef enum logic [1:0] {
        FETCH  = 2'd0,                        // Fetch next opcode, ALU works on operand
        DECODE = 2'd1,                        // Opcode valid, write back previous result
        REG    = 2'd2,                        // Register-to-register cycle
        ZP0    = 2'd3                         // Zero-page read or store
    } state_e;

    // Logic ops line up with opcode bits [6:5] of the ORA/AND/EOR/ADC group
    typedef enum logic [2:0] {
        OP_OR  = 3'd0,
        OP_AND = 3'd1,
        OP_EOR = 3'd2,
        OP_ADD = 3'd3,
        OP_SUB = 3'd4,                        // A + ~B + carry in
        OP_A   = 3'd5                         // Pass operand A
    } alu_op_e;

    // Registered at DECODE, valid for the rest of the instruction
    typedef struct packed {
        alu_op_e                alu_op;
        cpu_arch_pkg::reg_sel_e src_reg;      // Read in REG/FETCH/ZP0
        cpu_arch_pkg::reg_sel_e dst_reg;      // Written at next DECODE
        logic                   load_reg;     // Result goes to dst_reg
        logic                   load_only;    // LDA/LDX/LDY, operand A forced to 0
        logic                   store;        // STA/STX/STY
        logic                   adc_sbc;      // C from ALU, carry in from C
        logic                   adc_bcd;      // ADC with D set
        logic                   compare;      // CMP, C from ALU, no write
        logic                   inc;          // INX/INY carry in
        logic                   clc;
        logic                   sec;
        logic                   cld;
        logic                   sed;
    } ctrl_t;

endpackage

`default_nettype wire

//--- design/cpu_decode.sv
// Opcode decoder; latches the control word for the sequencer, ALU and registers in DECODE
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rdy,
    input  cpu_ctrl_pkg::state_e  state,
    input  cpu_arch_pkg::byte_t   ir,
    input  cpu_arch_pkg::flags_t  flags,
    output cpu_ctrl_pkg::ctrl_t   ctrl
);

    cpu_ctrl_pkg::ctrl_t dec;                 // Next control word
    logic                d_next;              // D as it will be after this DECODE

    // SED/CLD of the previous instruction land on this same edge
    assign d_next = ctrl.sed | (flags.decimal & ~ctrl.cld);

    always_comb begin
        dec = '0;
        dec.alu_op  = cpu_ctrl_pkg::OP_ADD;
        dec.src_reg = cpu_arch_pkg::SEL_A;
        dec.dst_reg = cpu_arch_pkg::SEL_A;
        casez (ir)
            8'b0??0_0101,
            8'b0??0_1001: begin                                   // ORA/AND/EOR/ADC
                dec.alu_op   = cpu_ctrl_pkg::alu_op_e'({1'b0, ir[6:5]});
                dec.load_reg = 1'b1;
                dec.adc_sbc  = (ir[6:5] == 2'b11);
                dec.adc_bcd  = (ir[6:5] == 2'b11) & d_next;
            end
            8'b11?0_0101,
            8'b11?0_1001: begin                                   // CMP, SBC
                dec.alu_op   = cpu_ctrl_pkg::OP_SUB;
                dec.compare  = ~ir[5];
                dec.adc_sbc  = ir[5];
                dec.load_reg = ir[5];                             // CMP leaves A alone
            end
            8'ha5, 8'ha9: begin                                   // LDA
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
            end
            8'ha6, 8'ha2: begin                                   // LDX
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
                dec.dst_reg   = cpu_arch_pkg::SEL_X;
            end
            8'ha4, 8'ha0: begin                                   // LDY
                dec.load_reg  = 1'b1;
                dec.load_only = 1'b1;
                dec.dst_reg   = cpu_arch_pkg::SEL_Y;
            end
            8'h85: dec.store = 1'b1;                              // STA
            8'h86: begin                                          // STX
                dec.store   = 1'b1;
                dec.src_reg = cpu_arch_pkg::SEL_X;
            end
            8'h84: begin                                          // STY
                dec.store   = 1'b1;
                dec.src_reg = cpu_arch_pkg::SEL_Y;
            end
            8'haa, 8'ha8: begin                                   // TAX, TAY
                dec.alu_op   = cpu_ctrl_pkg::OP_A;
                dec.load_reg = 1'b1;
                dec.dst_reg  = ir[1] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
            end
            8'h8a, 8'h98: begin                                   // TXA, TYA
                dec.alu_op   = cpu_ctrl_pkg::OP_A;
                dec.load_reg = 1'b1;
                dec.src_reg  = ir[1] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
            end
            8'he8, 8'hc8: begin                                   // INX, INY
                dec.inc      = 1'b1;
                dec.load_reg = 1'b1;
                dec.src_reg  = ir[5] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
                dec.dst_reg  = ir[5] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
            end
            8'hca, 8'h88: begin                                   // DEX, DEY, X/Y + ~0
                dec.alu_op   = cpu_ctrl_pkg::OP_SUB;
                dec.load_reg = 1'b1;
                dec.src_reg  = ir[6] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
                dec.dst_reg  = ir[6] ? cpu_arch_pkg::SEL_X : cpu_arch_pkg::SEL_Y;
            end
            8'h18: dec.clc = 1'b1;
            8'h38: dec.sec = 1'b1;
            8'hd8: dec.cld = 1'b1;
            8'hf8: dec.sed = 1'b1;
            default: ;                                            // NOP and unknown opcodes
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= '0;
        end else if (rdy && state == cpu_ctrl_pkg::DECODE) begin
            ctrl <= dec;
        end
    end

    // A store reads the register file, it never writes it back
    a_store_no_load: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.store && ctrl.load_reg));

endmodule

`default_nettype wire

//--- design/cpu_registers.sv
// A/X/Y register file with result write-back and C/D flag update of the core
`timescale 1ns/1ps
`default_nettype none

module cpu_registers (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rdy,
    input  cpu_ctrl_pkg::state_e  state,
    input  cpu_ctrl_pkg::ctrl_t   ctrl,
    input  cpu_arch_pkg::byte_t   result,
    input  logic                  carry_out,
    output cpu_arch_pkg::byte_t   regfile,
    output cpu_arch_pkg::flags_t  flags
);

    cpu_arch_pkg::byte_t    axy [3];          // A, X, Y
    cpu_arch_pkg::reg_sel_e regsel;
    cpu_arch_pkg::byte_t    res_q;            // ALU output of the last cycle
    logic                   co_q;

    // DECODE points at the destination of the finishing instruction
    assign regsel  = (state == cpu_ctrl_pkg::DECODE) ? ctrl.dst_reg : ctrl.src_reg;
    assign regfile = axy[regsel];

    always_ff @(posedge clk) begin
        if (rdy) begin
            res_q <= result;
            co_q  <= carry_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && state == cpu_ctrl_pkg::DECODE && ctrl.load_reg) begin
            axy[ctrl.dst_reg] <= res_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (rdy && state == cpu_ctrl_pkg::DECODE) begin
            if (ctrl.adc_sbc || ctrl.compare) begin
                flags.carry <= co_q;
            end else if (ctrl.sec) begin
                flags.carry <= 1'b1;
            end else if (ctrl.clc) begin
                flags.carry <= 1'b0;
            end
            if (ctrl.sed) begin
                flags.decimal <= 1'b1;
            end else if (ctrl.cld) begin
                flags.decimal <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cpu_sequencer.sv
// Core sequencer: state machine, PC, bus address and write strobe, data-in sampling under rdy
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    rdy,
    input  cpu_arch_pkg::byte_t     rdata,
    input  cpu_ctrl_pkg::ctrl_t     ctrl,
    input  cpu_arch_pkg::byte_t     regfile,
    output cpu_ctrl_pkg::state_e    state,
    output cpu_arch_pkg::byte_t     ir,
    output cpu_arch_pkg::byte_t     din,
    output cpu_arch_pkg::bus_req_t  bus
);

    cpu_ctrl_pkg::state_e next_state;
    cpu_arch_pkg::addr_t  pc;                 // Program counter
    cpu_arch_pkg::addr_t  ab_q;               // Address of the last completed cycle
    logic                 pc_inc;

    // Byte read in the last cycle with rdy high, kept through wait states
    always_ff @(posedge clk) begin
        if (rdy) begin
            din  <= rdata;
            ab_q <= bus.addr;
        end
    end

    assign ir = din;                          // Opcode arrives one cycle ahead of DECODE

    // Addressing mode from opcode bits only
    always_comb begin
        case (state)
            cpu_ctrl_pkg::DECODE: begin
                casez (din)
                    8'b???0_01??: next_state = cpu_ctrl_pkg::ZP0;     // zp column
                    8'b1010_00?0,
                    8'b???0_1001: next_state = cpu_ctrl_pkg::FETCH;   // #imm
                    default:      next_state = cpu_ctrl_pkg::REG;     // Implied
                endcase
            end
            cpu_ctrl_pkg::ZP0: next_state = cpu_ctrl_pkg::FETCH;
            default:           next_state = cpu_ctrl_pkg::DECODE;     // FETCH, REG
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu_ctrl_pkg::FETCH;
        end else if (rdy) begin
            state <= next_state;
        end
    end

    // Opcode and operand bytes consume PC, REG re-reads the prefetched opcode
    assign pc_inc = (state == cpu_ctrl_pkg::DECODE) || (state == cpu_ctrl_pkg::FETCH);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (rdy && pc_inc) begin
            pc <= pc + cpu_arch_pkg::addr_t'(1);
        end
    end

    always_comb begin
        case (state)
            cpu_ctrl_pkg::ZP0: bus.addr = {`CPU_ZERO_PAGE, din};       // Operand as address
            cpu_ctrl_pkg::REG: bus.addr = ab_q;                        // Same opcode again
            default:           bus.addr = pc;
        endcase
        bus.wdata = regfile;                                           // src_reg outside DECODE
        bus.we    = (state == cpu_ctrl_pkg::ZP0) && ctrl.store;
    end

    // ZP0 is only entered from the DECODE of the same instruction
    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {cpu_ctrl_pkg::FETCH, cpu_ctrl_pkg::DECODE,
                      cpu_ctrl_pkg::REG, cpu_ctrl_pkg::ZP0} &&
        (state != cpu_ctrl_pkg::ZP0 ||
         $past(state) inside {cpu_ctrl_pkg::DECODE, cpu_ctrl_pkg::ZP0}));

    // Write only in ZP0 of an opcode that was decoded as a store
    a_we_zp0: assert property (@(posedge clk) disable iff (reset)
        bus.we |-> state == cpu_ctrl_pkg::ZP0 &&
        ($past(state) == cpu_ctrl_pkg::ZP0 || $past(ir) inside {8'h85, 8'h86, 8'h84}));

    // Stalled write keeps address and data until memory takes it
    a_we_hold: assert property (@(posedge clk) disable iff (reset)
        bus.we && !rdy |=> $stable(bus));

endmodule

`default_nettype wire

//--- include/cpu_defs.svh
// Width, reset address and page constants for the 8-bit core; include wherever they are needed
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path width, one byte
`define CPU_DATA_W 8

// Address bus width
`define CPU_ADDR_W 16

// First opcode address after reset
`define CPU_RESET_PC 16'h0200

// Upper address byte for zero-page operands
`define CPU_ZERO_PAGE 8'h00

`endif

//--- src.f
+incdir+include
design/cpu_arch_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_decode.sv
design/cpu_sequencer.sv
design/cpu_alu.sv
design/cpu_registers.sv
design/cpu_core.sv
verif/cpu_tb.sv

//--- verif/cpu_tb.sv
// Testbench for the 8-bit core: runs one random program twice and checks every store against a model
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int PROG_LEN       = 40;           // Instructions
    localparam int STALL_FACTOR   = 8;            // Worst-case slowdown from rdy
    localparam int RUNS           = 2;
    localparam int TAIL_CYCLES    = 8;            // NOPs after the end, no write allowed
    localparam int TIMEOUT_CYCLES =
        RUNS * (RESET_CYCLES + PROG_LEN * 3 * STALL_FACTOR + TAIL_CYCLES + 4);

    // Flag and arithmetic ops first, drawn more often
    localparam int NUM_OPS = 31;
    localparam logic [NUM_OPS*8-1:0] PICK_OPS = {
        8'h69, 8'h65, 8'he9, 8'he5, 8'hc9, 8'hc5, 8'h18, 8'h38, 8'hd8, 8'hf8,
        8'ha9, 8'ha5, 8'ha2, 8'ha6, 8'ha0, 8'ha4, 8'h09, 8'h05, 8'h29, 8'h25,
        8'h49, 8'h45, 8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88,
        8'hea
    };
    localparam logic [23:0] STORE_OPS = {8'h85, 8'h86, 8'h84};   // STA, STX, STY

    logic                   clk;
    logic                   reset;
    logic                   rdy;
    cpu_arch_pkg::byte_t    rdata;
    cpu_arch_pkg::bus_req_t bus;

    cpu_arch_pkg::byte_t    mem [65536];           // Whole address space
    cpu_arch_pkg::byte_t    zp_init [256];         // Random zero-page contents
    cpu_arch_pkg::byte_t    zp_model [256];
    cpu_arch_pkg::byte_t    prog_op [PROG_LEN];
    cpu_arch_pkg::byte_t    prog_arg [PROG_LEN];   // Operand, unused for implied
    cpu_arch_pkg::addr_t    done_addr;             // Address read in DECODE of first tail NOP
    cpu_arch_pkg::bus_req_t model_q [$];           // Expected writes in program order
    cpu_arch_pkg::bus_req_t exp_q [$];
    cpu_arch_pkg::bus_req_t head;
    cpu_arch_pkg::bus_req_t bus_q;                 // Bus of the previous cycle
    logic [31:0]            lfsr = 32'ha7556c75;
    logic                   rdy_random;
    logic                   checking;
    logic                   stalled_q;
    int                     errors;
    int                     writes;
    int                     n_stores;
    int                     tests_run;
    int                     tests_failed;

    assign rdata = mem[bus.addr];                  // Combinational read

    cpu_core dut0 (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .rdata (rdata),
        .bus   (bus)
    );

    // Fibonacci LFSR, taps 32/22/2/1, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic is_zero_page(input cpu_arch_pkg::byte_t op);
        return op[3:2] == 2'b01;                   // x4..x7 column
    endfunction

    function automatic logic is_implied(input cpu_arch_pkg::byte_t op);
        return !is_zero_page(op) && op[3:0] != 4'h9 && op != 8'ha0 && op != 8'ha2;
    endfunction

    // ADC, returns {carry, sum}
    function automatic logic [8:0] add_model(input cpu_arch_pkg::byte_t a,
                                             input cpu_arch_pkg::byte_t b,
                                             input logic c, input logic d);
        logic [4:0] lo;
        logic [4:0] hi;
        logic       half;
        logic       carry;
        if (!d) begin
            return {1'b0, a} + {1'b0, b} + 9'(c);
        end
        lo   = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(c);
        half = lo > 5'd9;
        if (half) lo = lo + 5'd6;                  // Skip past the invalid digits
        hi    = {1'b0, a[7:4]} + {1'b0, b[7:4]} + 5'(half);
        carry = hi > 5'd9;
        if (carry) hi = hi + 5'd6;
        return {carry, hi[3:0], lo[3:0]};
    endfunction

    // SBC, returns {carry, difference}
    function automatic logic [8:0] sub_model(input cpu_arch_pkg::byte_t a,
                                             input cpu_arch_pkg::byte_t b,
                                             input logic c, input logic d);
        logic [8:0] sum;
        logic [4:0] lo;
        sum = {1'b0, a} + {1'b0, ~b} + 9'(c);
        lo  = {1'b0, a[3:0]} + {1'b0, ~b[3:0]} + 5'(c);
        if (d && !lo[4]) sum[3:0] = sum[3:0] + 4'd10;      // Low digit borrowed
        if (d && !sum[8]) sum[7:4] = sum[7:4] + 4'd10;     // High digit borrowed
        return sum;
    endfunction

    task automatic store_model(input cpu_arch_pkg::byte_t zp_addr,
                               input cpu_arch_pkg::byte_t data);
        model_q.push_back(cpu_arch_pkg::bus_req_t'({`CPU_ZERO_PAGE, zp_addr, data, 1'b1}));
        zp_model[zp_addr] = data;
        n_stores++;
    endtask

    // Three loads set up A/X/Y, then stores alternate with random ops
    task automatic build_program();
        int i;
        for (i = 0; i < PROG_LEN; i++) begin
            if (i < 3) begin
                prog_op[i] = (i == 0) ? 8'ha9 : (i == 1) ? 8'ha2 : 8'ha0;
            end else if (i % 2 == 0) begin
                prog_op[i] = STORE_OPS[8 * (next_bits(8) % 3) +: 8];
            end else if (next_bits(1)) begin
                prog_op[i] = PICK_OPS[8 * (NUM_OPS - 1 - next_bits(8) % 10) +: 8];
            end else begin
                prog_op[i] = PICK_OPS[8 * (NUM_OPS - 1 - next_bits(8) % NUM_OPS) +: 8];
            end
            prog_arg[i] = next_bits(8);
        end
        for (i = 0; i < 256; i++) begin
            zp_init[i] = next_bits(8);
        end
    endtask

    // Instruction-level model, fills model_q
    task automatic run_model();
        cpu_arch_pkg::byte_t a;
        cpu_arch_pkg::byte_t x;
        cpu_arch_pkg::byte_t y;
        cpu_arch_pkg::byte_t v;
        logic                c;
        logic                d;
        int                  i;
        a = '0;
        x = '0;
        y = '0;
        c = 1'b0;                                  // Flags clear after reset
        d = 1'b0;
        model_q.delete();
        n_stores = 0;
        for (i = 0; i < 256; i++) begin
            zp_model[i] = zp_init[i];
        end
        for (i = 0; i < PROG_LEN; i++) begin
            v = is_zero_page(prog_op[i]) ? zp_model[prog_arg[i]] : prog_arg[i];
            case (prog_op[i])
                8'ha9, 8'ha5: a = v;
                8'ha2, 8'ha6: x = v;
                8'ha0, 8'ha4: y = v;
                8'h85:        store_model(prog_arg[i], a);
                8'h86:        store_model(prog_arg[i], x);
                8'h84:        store_model(prog_arg[i], y);
                8'h09, 8'h05: a = a | v;
                8'h29, 8'h25: a = a & v;
                8'h49, 8'h45: a = a ^ v;
                8'h69, 8'h65: {c, a} = add_model(a, v, c, d);
                8'he9, 8'he5: {c, a} = sub_model(a, v, c, d);
                8'hc9, 8'hc5: c = (a >= v);        // A unchanged
                8'haa:        x = a;
                8'ha8:        y = a;
                8'h8a:        a = x;
                8'h98:        a = y;
                8'he8:        x = x + 8'd1;
                8'hc8:        y = y + 8'd1;
                8'hca:        x = x - 8'd1;
                8'h88:        y = y - 8'd1;
                8'h18:        c = 1'b0;
                8'h38:        c = 1'b1;
                8'hd8:        d = 1'b0;
                8'hf8:        d = 1'b1;
                default:      ;                    // NOP
            endcase
        end
    endtask

    task automatic load_memory();
        cpu_arch_pkg::addr_t a;
        int                  i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = (i < 256) ? zp_init[i] : 8'hea;   // NOPs past the program
        end
        a = `CPU_RESET_PC;
        for (i = 0; i < PROG_LEN; i++) begin
            mem[a] = prog_op[i];
            a++;
            if (!is_implied(prog_op[i])) begin
                mem[a] = prog_arg[i];
                a++;
            end
        end
        done_addr = a + cpu_arch_pkg::addr_t'(1);
    endtask

    task automatic run_program(input logic random_rdy, input string name);
        int errors_at_start;
        errors_at_start = errors;
        rdy_random      = random_rdy;
        @(posedge clk);
        #1;
        reset = 1'b1;
        load_memory();
        exp_q  = model_q;
        writes = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        while (!rdy) @(posedge clk);               // First cycle the core advances
        assert (bus.addr == `CPU_RESET_PC) else begin
            $display("FAILED %0t ns: bus.addr expected %04h got %04h",
                     $time, `CPU_RESET_PC, bus.addr);
            errors++;
        end
        assert (!bus.we) else begin
            $display("FAILED %0t ns: bus.we expected 0 got %0b", $time, bus.we);
            errors++;
        end
        #1;
        checking = 1'b1;
        while (bus.addr != done_addr) @(posedge clk);
        repeat (TAIL_CYCLES) @(posedge clk);
        #1;
        checking = 1'b0;
        assert (writes == n_stores) else begin
            $display("wrong number of writes: %0d seen for %0d stores in the program",
                     writes, n_stores);
            errors++;
        end
        tests_run++;
        if (errors != errors_at_start) tests_failed++;
        $display("test %s: %0d of %0d writes, %0d errors",
                 name, writes, n_stores, errors - errors_at_start);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Random wait states, about one cycle in four
    always @(posedge clk) begin
        #1;
        if (rdy_random) rdy = (next_bits(2) != 2'b00);
        else rdy = 1'b1;
    end

    always @(posedge clk) begin
        if (!reset && bus.we && rdy) mem[bus.addr] <= bus.wdata;
    end

    // Write and stall monitor
    always @(posedge clk) begin
        if (reset) begin
            assert (!bus.we) else begin
                $display("FAILED %0t ns: bus.we expected 0 got %0b", $time, bus.we);
                errors++;
            end
        end else if (checking) begin
            if (stalled_q) begin                   // Nothing may move under rdy low
                assert (bus == bus_q) else begin
                    $display("FAILED %0t ns: bus expected %07h got %07h", $time, bus_q, bus);
                    errors++;
                end
            end
            if (bus.we && rdy) begin
                writes++;
                if (exp_q.size() == 0) begin
                    $display("at %0t ns the core wrote %02h to %04h after the last store",
                             $time, bus.wdata, bus.addr);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    assert (bus.addr == head.addr) else begin
                        $display("FAILED %0t ns: bus.addr expected %04h got %04h",
                                 $time, head.addr, bus.addr);
                        errors++;
                    end
                    assert (bus.wdata == head.wdata) else begin
                        $display("FAILED %0t ns: bus.wdata expected %02h got %02h",
                                 $time, head.wdata, bus.wdata);
                        errors++;
                    end
                end
            end
            stalled_q = !rdy;
            bus_q     = bus;
        end else begin
            stalled_q = 1'b0;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not reach its end within %0d cycles",
                 TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        rdy          = 1'b0;
        rdy_random   = 1'b0;
        checking     = 1'b0;
        stalled_q    = 1'b0;
        errors       = 0;
        writes       = 0;
        tests_run    = 0;
        tests_failed = 0;
        build_program();
        run_model();
        load_memory();
        run_program(1'b0, "rdy high");
        run_program(1'b1, "random rdy");
        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
